// File: Bender.yml
package:
  name: riscv_dpath

sources:
  - riscv_pkg.sv
  - riscv_stage_reg.sv
  - riscv_regfile.sv
  - riscv_alu.sv
  - riscv_fetch.sv
  - riscv_decode.sv
  - riscv_execute.sv
  - riscv_mem_stage.sv
  - riscv_dpath.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_riscv_dpath.sv

// File: riscv_alu.sv
/* Combinational integer ALU for the execute stage, eleven functions.
   Shifts take their amount from the low five bits of in1 */
`timescale 1ns/1ns

module riscv_alu import riscv_pkg::*; (
  input  logic [xlen-1:0] in0,
  input  logic [xlen-1:0] in1,
  input  alu_fn_t         fn,
  output logic [xlen-1:0] out
);

  logic [4:0] shamt;
  logic       lt_s;
  logic       lt_u;

  assign shamt = in1[4:0];
  assign lt_s  = $signed(in0) < $signed(in1);
  assign lt_u  = in0 < in1;

  always_comb begin
    case (fn)
      alu_add: out = in0 + in1;
      alu_sub: out = in0 - in1;
      alu_sll: out = in0 << shamt;
      alu_or:  out = in0 | in1;
      // Set-less-than gives 0 or 1
      alu_lt:  out = {{(xlen-1){1'b0}}, lt_s};
      alu_ltu: out = {{(xlen-1){1'b0}}, lt_u};
      alu_and: out = in0 & in1;
      alu_xor: out = in0 ^ in1;
      alu_nor: out = ~(in0 | in1);
      alu_srl: out = in0 >> shamt;
      alu_sra: out = $signed(in0) >>> shamt;  // Sign bit fills from the top
      default: out = '0;
    endcase
  end

endmodule

// File: riscv_decode.sv
/* Decode stage: instruction fields, immediates, register reads and the
   operand selects. Output is the execute payload, registered outside */
`timescale 1ns/1ns

module riscv_decode import riscv_pkg::*; (
  input  dec_pay_t              dec_pay,
  output logic [reg_addr_w-1:0] rf_raddr0,
  output logic [reg_addr_w-1:0] rf_raddr1,
  input  logic [xlen-1:0]       rf_rdata0,
  input  logic [xlen-1:0]       rf_rdata1,
  output exe_pay_t              exe_pay
);

  logic [xlen-1:0]       inst;
  logic [reg_addr_w-1:0] rs1;
  logic [reg_addr_w-1:0] rs2;
  logic [reg_addr_w-1:0] rd;
  logic [xlen-1:0]       shamt;
  logic [xlen-1:0]       imm_i;
  logic [xlen-1:0]       imm_s;
  logic [xlen-1:0]       imm_sb;
  logic [xlen-1:0]       imm_u;

  // --------------------
  // Field extraction
  // --------------------
  assign inst  = dec_pay.inst;
  assign rs1   = inst[19:15];
  assign rs2   = inst[24:20];
  assign rd    = inst[11:7];
  assign shamt = {{(xlen-5){1'b0}}, inst[24:20]};   // Zero extended

  // Immediates, all sign extended from inst[31]
  assign imm_i  = {{(xlen-12){inst[31]}}, inst[31:20]};
  assign imm_s  = {{(xlen-12){inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_sb = {{(xlen-13){inst[31]}}, inst[31], inst[7], inst[30:25],
                   inst[11:8], 1'b0};
  assign imm_u  = {inst[31:12], 12'b0};

  assign rf_raddr0 = rs1;
  assign rf_raddr1 = rs2;

  // --------------------
  // Operand selects
  // --------------------
  always_comb begin
    exe_pay.pc         = dec_pay.pc;
    exe_pay.store_data = rf_rdata1;  // rs2 value for stores
    exe_pay.rd         = rd;
    exe_pay.imm_sb     = imm_sb;
    exe_pay.ctrl       = dec_pay.ctrl;

    case (dec_pay.ctrl.op0_sel)
      op0_rs1: exe_pay.op0 = rf_rdata0;
      op0_pc:  exe_pay.op0 = dec_pay.pc;
      op0_pc4: exe_pay.op0 = dec_pay.pc_plus4;
      default: exe_pay.op0 = '0;
    endcase

    case (dec_pay.ctrl.op1_sel)
      op1_rs2:    exe_pay.op1 = rf_rdata1;
      op1_shamt:  exe_pay.op1 = shamt;
      op1_imm_u:  exe_pay.op1 = imm_u;
      op1_imm_sb: exe_pay.op1 = imm_sb;
      op1_imm_i:  exe_pay.op1 = imm_i;
      op1_imm_s:  exe_pay.op1 = imm_s;
      default:    exe_pay.op1 = '0;   // op1_zero
    endcase
  end

endmodule

// File: riscv_dpath.sv
/* Top of the five-stage RISC-V datapath. Connects fetch, decode, execute,
   memory and writeback through stage registers and the register file */
`timescale 1ns/1ns

module riscv_dpath import riscv_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  // Fetch and issue
  output logic [xlen-1:0]       imem_addr,
  input  logic [xlen-1:0]       inst,
  input  logic                  issue_valid,
  input  ctrl_t                 ctrl,
  output logic                  issue_rdy,
  // Data memory, Wishbone classic
  output logic                  wb_cyc,
  output logic                  wb_stb,
  output logic                  wb_we,
  output logic [xlen-1:0]       wb_adr,
  output logic [xlen-1:0]       wb_dat_w,
  output logic [sel_w-1:0]      wb_sel,
  input  logic [xlen-1:0]       wb_dat_r,
  input  logic                  wb_ack,
  // Status
  output logic                  wb_valid,
  output logic [reg_addr_w-1:0] wb_rd,
  output logic [xlen-1:0]       wb_data,
  output br_cond_t              br_cond
);

  logic            stall;
  logic            redirect_valid;
  logic [xlen-1:0] redirect_pc;
  logic [reg_addr_w-1:0] rf_raddr0, rf_raddr1;
  logic [xlen-1:0]       rf_rdata0, rf_rdata1;

  logic f_valid, d_valid, x_valid, m_valid, w_valid;
  dec_pay_t f_pay, d_pay;
  exe_pay_t dx_pay, x_pay;
  mem_pay_t xm_pay, m_pay;
  wb_pay_t  mw_pay, w_pay;

  assign issue_rdy = !stall;

  riscv_fetch fetch_i (
    .clk (clk), .reset (reset), .stall (stall),
    .issue_valid (issue_valid), .inst (inst), .ctrl (ctrl),
    .redirect_valid (redirect_valid), .redirect_pc (redirect_pc),
    .imem_addr (imem_addr), .dec_valid (f_valid), .dec_pay (f_pay)
  );

  riscv_stage_reg #(.payload_t(dec_pay_t)) d_reg (
    .clk (clk), .reset (reset), .hold (stall),
    .valid_in (f_valid), .pay_in (f_pay), .valid_out (d_valid), .pay_out (d_pay)
  );

  riscv_decode decode_i (
    .dec_pay (d_pay), .rf_raddr0 (rf_raddr0), .rf_raddr1 (rf_raddr1),
    .rf_rdata0 (rf_rdata0), .rf_rdata1 (rf_rdata1), .exe_pay (dx_pay)
  );

  riscv_stage_reg #(.payload_t(exe_pay_t)) x_reg (
    .clk (clk), .reset (reset), .hold (stall),
    .valid_in (d_valid), .pay_in (dx_pay), .valid_out (x_valid), .pay_out (x_pay)
  );

  riscv_execute execute_i (
    .exe_valid (x_valid), .exe_pay (x_pay), .mem_pay (xm_pay), .br_cond (br_cond),
    .redirect_valid (redirect_valid), .redirect_pc (redirect_pc)
  );

  riscv_stage_reg #(.payload_t(mem_pay_t)) m_reg (
    .clk (clk), .reset (reset), .hold (stall),
    .valid_in (x_valid), .pay_in (xm_pay), .valid_out (m_valid), .pay_out (m_pay)
  );

  riscv_mem_stage mem_i (
    .clk (clk), .reset (reset), .mem_valid (m_valid), .mem_pay (m_pay),
    .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we), .wb_adr (wb_adr),
    .wb_dat_w (wb_dat_w), .wb_sel (wb_sel), .wb_dat_r (wb_dat_r), .wb_ack (wb_ack),
    .stall (stall), .wb_pay (mw_pay)
  );

  riscv_stage_reg #(.payload_t(wb_pay_t)) w_reg (
    .clk (clk), .reset (reset), .hold (stall),
    .valid_in (m_valid), .pay_in (mw_pay), .valid_out (w_valid), .pay_out (w_pay)
  );

  // Write lands only on the advancing edge that ends writeback
  riscv_regfile regfile_i (
    .clk (clk), .raddr0 (rf_raddr0), .rdata0 (rf_rdata0),
    .raddr1 (rf_raddr1), .rdata1 (rf_rdata1),
    .wen (w_valid && w_pay.rf_wen && !stall), .waddr (w_pay.rd), .wdata (w_pay.data)
  );

  assign wb_valid = w_valid;
  assign wb_rd    = w_pay.rd;
  assign wb_data  = w_pay.data;

endmodule

// File: riscv_execute.sv
/* Execute stage: ALU, the six branch flags and the taken decision. A valid
   taken branch redirects fetch to PC plus the SB immediate */
`timescale 1ns/1ns

module riscv_execute import riscv_pkg::*; (
  input  logic            exe_valid,
  input  exe_pay_t        exe_pay,
  output mem_pay_t        mem_pay,
  output br_cond_t        br_cond,
  output logic            redirect_valid,
  output logic [xlen-1:0] redirect_pc
);

  logic [xlen-1:0] alu_out;
  logic            taken;

  riscv_alu alu_i (
    .in0 (exe_pay.op0),
    .in1 (exe_pay.op1),
    .fn  (exe_pay.ctrl.alu_fn),
    .out (alu_out)
  );

  // --------------------
  // Branch condition
  // --------------------
  assign br_cond.eq  = exe_pay.op0 == exe_pay.op1;
  assign br_cond.ne  = exe_pay.op0 != exe_pay.op1;
  assign br_cond.lt  = $signed(exe_pay.op0) < $signed(exe_pay.op1);
  assign br_cond.ltu = exe_pay.op0 < exe_pay.op1;
  assign br_cond.ge  = $signed(exe_pay.op0) >= $signed(exe_pay.op1);
  assign br_cond.geu = exe_pay.op0 >= exe_pay.op1;

  always_comb begin
    case (exe_pay.ctrl.br_type)
      br_beq:  taken = br_cond.eq;
      br_bne:  taken = br_cond.ne;
      br_blt:  taken = br_cond.lt;
      br_bltu: taken = br_cond.ltu;
      br_bge:  taken = br_cond.ge;
      br_bgeu: taken = br_cond.geu;
      default: taken = 1'b0;          // br_none
    endcase
  end

  // Bubbles never redirect
  assign redirect_valid = exe_valid && taken;
  assign redirect_pc    = exe_pay.pc + exe_pay.imm_sb;

  // --------------------
  // Memory payload
  // --------------------
  assign mem_pay.result     = alu_out;
  assign mem_pay.store_data = exe_pay.store_data;
  assign mem_pay.rd         = exe_pay.rd;
  assign mem_pay.mem_op     = exe_pay.ctrl.mem_op;
  assign mem_pay.mem_len    = exe_pay.ctrl.mem_len;
  assign mem_pay.wb_sel     = exe_pay.ctrl.wb_sel;
  assign mem_pay.rf_wen     = exe_pay.ctrl.rf_wen;

endmodule

// File: riscv_fetch.sv
/* Fetch stage: PC register with +4 step and branch redirect. Drives the
   instruction memory address and packs the fetched word for decode */
`timescale 1ns/1ns

module riscv_fetch import riscv_pkg::*; (
  input  logic            clk,
  input  logic            reset,
  input  logic            stall,
  input  logic            issue_valid,
  input  logic [xlen-1:0] inst,
  input  ctrl_t           ctrl,
  input  logic            redirect_valid,
  input  logic [xlen-1:0] redirect_pc,
  output logic [xlen-1:0] imem_addr,
  output logic            dec_valid,
  output dec_pay_t        dec_pay
);

  logic [xlen-1:0] pc;
  logic [xlen-1:0] pc_plus4;

  assign pc_plus4  = pc + 32'd4;
  assign imem_addr = pc;             // inst comes back in the same cycle

  // Redirect wins over the sequential step
  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= reset_vector;
    end else if (!stall) begin
      if (redirect_valid) begin
        pc <= redirect_pc;
      end else if (issue_valid) begin
        pc <= pc_plus4;              // Step only on an accepted instruction
      end
    end
  end

  assign dec_valid        = issue_valid;
  assign dec_pay.inst     = inst;
  assign dec_pay.pc       = pc;
  assign dec_pay.pc_plus4 = pc_plus4;
  assign dec_pay.ctrl     = ctrl;

endmodule

// File: riscv_mem_stage.sv
/* Memory stage: Wishbone classic master for loads and stores, byte lanes,
   load extension and the writeback select. Stalls the pipe until ack */
`timescale 1ns/1ns

module riscv_mem_stage import riscv_pkg::*; (
  input  logic             clk,
  input  logic             reset,
  input  logic             mem_valid,
  input  mem_pay_t         mem_pay,
  output logic             wb_cyc,
  output logic             wb_stb,
  output logic             wb_we,
  output logic [xlen-1:0]  wb_adr,
  output logic [xlen-1:0]  wb_dat_w,
  output logic [sel_w-1:0] wb_sel,
  input  logic [xlen-1:0]  wb_dat_r,
  input  logic             wb_ack,
  output logic             stall,
  output wb_pay_t          wb_pay
);

  logic            access_req;
  logic            active;           // Bus cycle in flight
  logic [1:0]      byte_off;
  logic [xlen-1:0] lane;
  logic [xlen-1:0] load_val;

  assign access_req = mem_valid && (mem_pay.mem_op != mem_none);
  assign byte_off   = mem_pay.result[1:0];

  // --------------------
  // Access state
  // --------------------
  // Cycle opens one clock after entry, drops on the edge after ack
  always_ff @(posedge clk) begin
    if (reset) begin
      active <= 1'b0;
    end else if (active) begin
      if (wb_ack) begin
        active <= 1'b0;
      end
    end else if (access_req) begin
      active <= 1'b1;
    end
  end

  assign stall  = access_req && !(active && wb_ack);  // Ack cycle advances
  assign wb_cyc = active;
  assign wb_stb = active;
  assign wb_we  = mem_pay.mem_op == mem_store;
  assign wb_adr = {mem_pay.result[xlen-1:2], 2'b00};  // Word address, lanes via sel

  // Store data replicated, sel marks the bytes
  always_comb begin
    case (mem_pay.mem_len)
      len_b, len_bu: begin
        wb_dat_w = {sel_w{mem_pay.store_data[7:0]}};
        wb_sel   = {{(sel_w-1){1'b0}}, 1'b1} << byte_off;
      end
      len_h, len_hu: begin
        wb_dat_w = {(sel_w/2){mem_pay.store_data[15:0]}};
        wb_sel   = {{(sel_w-2){1'b0}}, 2'b11} << {byte_off[1], 1'b0};
      end
      default: begin
        wb_dat_w = mem_pay.store_data;
        wb_sel   = '1;
      end
    endcase
  end

  // --------------------
  // Load extension
  // --------------------
  assign lane = wb_dat_r >> {byte_off, 3'b000};   // Addressed byte to bit 0

  always_comb begin
    case (mem_pay.mem_len)
      len_b:   load_val = {{(xlen-8){lane[7]}}, lane[7:0]};
      len_bu:  load_val = {{(xlen-8){1'b0}}, lane[7:0]};
      len_h:   load_val = {{(xlen-16){lane[15]}}, lane[15:0]};
      len_hu:  load_val = {{(xlen-16){1'b0}}, lane[15:0]};
      default: load_val = wb_dat_r;
    endcase
  end

  assign wb_pay.rd     = mem_pay.rd;
  assign wb_pay.data   = (mem_pay.wb_sel == wb_mem) ? load_val : mem_pay.result;
  assign wb_pay.rf_wen = mem_pay.rf_wen;

endmodule

// File: riscv_pkg.sv
/* Widths, select encodings, control word and stage payloads shared by the
   five-stage RISC-V datapath. Imported by every RTL module and the testbench */
package riscv_pkg;

  // --------------------
  // Widths and constants
  // --------------------
  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;
  localparam int sel_w      = xlen / 8;                // Wishbone byte selects
  localparam logic [xlen-1:0] reset_vector = 32'h0008_0000;

  // --------------------
  // Select encodings
  // --------------------
  typedef enum logic [1:0] {
    op0_rs1, op0_pc, op0_pc4, op0_zero
  } op0_sel_t;

  typedef enum logic [2:0] {
    op1_rs2, op1_shamt, op1_imm_u, op1_imm_sb, op1_imm_i, op1_imm_s, op1_zero
  } op1_sel_t;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_or, alu_lt, alu_ltu,
    alu_and, alu_xor, alu_nor, alu_srl, alu_sra
  } alu_fn_t;

  typedef enum logic [2:0] {
    br_none, br_beq, br_bne, br_blt, br_bltu, br_bge, br_bgeu
  } br_type_t;

  typedef enum logic [1:0] {
    mem_none, mem_load, mem_store
  } mem_op_t;

  // Store only looks at the size, unsigned variants matter for loads
  typedef enum logic [2:0] {
    len_w, len_b, len_bu, len_h, len_hu
  } mem_len_t;

  typedef enum logic {
    wb_alu, wb_mem
  } wb_sel_t;

  // Control word issued alongside each instruction
  typedef struct packed {
    op0_sel_t op0_sel;
    op1_sel_t op1_sel;
    alu_fn_t  alu_fn;
    br_type_t br_type;
    mem_op_t  mem_op;
    mem_len_t mem_len;
    wb_sel_t  wb_sel;
    logic     rf_wen;
  } ctrl_t;

  typedef struct packed {
    logic eq;
    logic ne;
    logic lt;
    logic ltu;
    logic ge;
    logic geu;
  } br_cond_t;

  // --------------------
  // Stage payloads
  // --------------------
  typedef struct packed {
    logic [xlen-1:0] inst;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] pc_plus4;
    ctrl_t           ctrl;
  } dec_pay_t;

  typedef struct packed {
    logic [xlen-1:0]       pc;
    logic [xlen-1:0]       op0;
    logic [xlen-1:0]       op1;
    logic [xlen-1:0]       store_data;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       imm_sb;     // Branch offset
    ctrl_t                 ctrl;
  } exe_pay_t;

  typedef struct packed {
    logic [xlen-1:0]       result;     // ALU out, also the data address
    logic [xlen-1:0]       store_data;
    logic [reg_addr_w-1:0] rd;
    mem_op_t               mem_op;
    mem_len_t              mem_len;
    wb_sel_t               wb_sel;
    logic                  rf_wen;
  } mem_pay_t;

  typedef struct packed {
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       data;
    logic                  rf_wen;
  } wb_pay_t;

endpackage

// File: riscv_regfile.sv
/* Integer register file, 32 x 32, two combinational read ports and one
   write port. x0 reads as zero and ignores writes */
`timescale 1ns/1ns

module riscv_regfile import riscv_pkg::*; (
  input  logic                  clk,
  input  logic [reg_addr_w-1:0] raddr0,
  output logic [xlen-1:0]       rdata0,
  input  logic [reg_addr_w-1:0] raddr1,
  output logic [xlen-1:0]       rdata1,
  input  logic                  wen,
  input  logic [reg_addr_w-1:0] waddr,
  input  logic [xlen-1:0]       wdata
);

  logic [xlen-1:0] regs [2**reg_addr_w];

  // No bypass, a same-cycle write shows up after the edge
  assign rdata0 = (raddr0 == '0) ? '0 : regs[raddr0];
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];

  always_ff @(posedge clk) begin
    if (wen && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

endmodule

// File: riscv_stage_reg.sv
/* Pipeline register between two stages: a valid bit plus a payload of any
   type, frozen as a whole while hold is high */
`timescale 1ns/1ns

module riscv_stage_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     hold,
  input  logic     valid_in,
  input  payload_t pay_in,
  output logic     valid_out,
  output payload_t pay_out
);

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_out <= 1'b0;             // Empty pipe after reset
    end else if (!hold) begin
      valid_out <= valid_in;
    end
  end

  // Payload only matters while valid is set
  always_ff @(posedge clk) begin
    if (!hold) begin
      pay_out <= pay_in;
    end
  end

endmodule

// File: sim.f
+incdir+.
riscv_pkg.sv
riscv_stage_reg.sv
riscv_regfile.sv
riscv_alu.sv
riscv_fetch.sv
riscv_decode.sv
riscv_execute.sv
riscv_mem_stage.sv
riscv_dpath.sv
tb_riscv_dpath.sv

// File: tb_riscv_model.svh
/* Reference model for the datapath testbench. Shadow registers, sparse memory,
   instruction encoders and expected-result queues, included inside the testbench */
`ifndef TB_RISCV_MODEL_SVH
`define TB_RISCV_MODEL_SVH

typedef struct packed {
  logic [31:0]           tag;        // Advancing edge of acceptance
  logic [reg_addr_w-1:0] rd;
  logic [xlen-1:0]       data;
} rf_wr_t;

typedef struct packed {
  logic [xlen-1:0]  adr;
  logic [xlen-1:0]  dat;
  logic [sel_w-1:0] sel;
  logic             we;
} bus_exp_t;

logic [xlen-1:0] shadow_rf [32];
logic [xlen-1:0] model_mem [logic [xlen-1:0]];   // Updated at issue
logic [xlen-1:0] bus_mem [logic [xlen-1:0]];     // Updated at ack
rf_wr_t          pend_q [$];                     // Writes not yet visible
wb_pay_t         exp_wb_q [$];
bus_exp_t        exp_bus_q [$];
logic [xlen-1:0] x_op0 [int];                    // Keyed by acceptance edge
logic [xlen-1:0] x_op1 [int];
logic [xlen-1:0] br_target [int];                // Present only when taken
bit              is_mem [int];

// Untouched words, pattern spread over the whole address
function automatic logic [xlen-1:0] fill_word(input logic [xlen-1:0] a);
  return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
endfunction

function automatic logic [xlen-1:0] rf_read(input logic [reg_addr_w-1:0] r);
  return (r == 0) ? '0 : shadow_rf[r];
endfunction

// RV32 immediate formats
function automatic logic [xlen-1:0] op1_value(input op1_sel_t s, input logic [xlen-1:0] i,
                                              input logic [xlen-1:0] rs2v);
  case (s)
    op1_rs2:    return rs2v;
    op1_shamt:  return {27'b0, i[24:20]};
    op1_imm_u:  return {i[31:12], 12'h000};
    op1_imm_sb: return {{19{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
    op1_imm_i:  return {{20{i[31]}}, i[31:20]};
    op1_imm_s:  return {{20{i[31]}}, i[31:25], i[11:7]};
    default:    return '0;
  endcase
endfunction

function automatic logic [xlen-1:0] alu_model(input alu_fn_t fn, input logic [xlen-1:0] a,
                                              input logic [xlen-1:0] b);
  case (fn)
    alu_add: return a + b;
    alu_sub: return a - b;
    alu_sll: return a << b[4:0];
    alu_or:  return a | b;
    alu_lt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    alu_ltu: return (a < b) ? 32'd1 : 32'd0;
    alu_and: return a & b;
    alu_xor: return a ^ b;
    alu_nor: return ~(a | b);
    alu_srl: return a >> b[4:0];
    alu_sra: return $signed(a) >>> b[4:0];
    default: return '0;
  endcase
endfunction

function automatic br_cond_t cond_of(input logic [xlen-1:0] a, input logic [xlen-1:0] b);
  br_cond_t f;
  f.eq  = (a == b);
  f.ne  = (a != b);
  f.lt  = ($signed(a) < $signed(b));
  f.ltu = (a < b);
  f.ge  = !f.lt;
  f.geu = !f.ltu;
  return f;
endfunction

function automatic logic taken_model(input br_type_t t, input br_cond_t f);
  case (t)
    br_beq:  return f.eq;
    br_bne:  return f.ne;
    br_blt:  return f.lt;
    br_bltu: return f.ltu;
    br_bge:  return f.ge;
    br_bgeu: return f.geu;
    default: return 1'b0;
  endcase
endfunction

// Word address, replicated data and byte enables
function automatic bus_exp_t bus_fields(input logic [xlen-1:0] a, input mem_len_t len,
                                        input logic [xlen-1:0] d, input logic we);
  bus_exp_t bx;
  bx.adr = {a[xlen-1:2], 2'b00};
  bx.we  = we;
  case (len)
    len_b, len_bu: begin
      bx.dat = {4{d[7:0]}};
      bx.sel = 4'b0001 << a[1:0];
    end
    len_h, len_hu: begin
      bx.dat = {2{d[15:0]}};
      bx.sel = 4'b0011 << a[1:0];
    end
    default: begin
      bx.dat = d;
      bx.sel = 4'hf;
    end
  endcase
  return bx;
endfunction

function automatic logic [xlen-1:0] merge_bytes(input logic [xlen-1:0] old,
                                                input logic [xlen-1:0] d,
                                                input logic [sel_w-1:0] sel);
  logic [xlen-1:0] w;
  w = old;
  for (int k = 0; k < sel_w; k++) begin
    if (sel[k]) w[8*k +: 8] = d[8*k +: 8];
  end
  return w;
endfunction

function automatic logic [xlen-1:0] load_ext(input logic [xlen-1:0] word,
                                             input logic [1:0] off, input mem_len_t len);
  logic [xlen-1:0] lane;
  lane = word >> (8 * off);
  case (len)
    len_b:   return {{24{lane[7]}}, lane[7:0]};
    len_bu:  return {24'b0, lane[7:0]};
    len_h:   return {{16{lane[15]}}, lane[15:0]};
    len_hu:  return {16'b0, lane[15:0]};
    default: return word;
  endcase
endfunction

// --------------------
// Encoders
// --------------------
function automatic logic [xlen-1:0] enc_load(input logic [4:0] rd, input logic [11:0] a,
                                             input logic [4:0] rs1);
  return {a, rs1, 3'b010, rd, 7'b0000011};
endfunction

function automatic logic [xlen-1:0] enc_store(input logic [4:0] rs2, input logic [11:0] a,
                                              input logic [4:0] rs1);
  return {a[11:5], rs2, rs1, 3'b010, a[4:0], 7'b0100011};
endfunction

// Accepted at edge j with PC pc, reads see writes accepted 4+ edges before
task automatic model_issue(input int j, input ctrl_t c, input logic [xlen-1:0] i,
                           input logic [xlen-1:0] pc);
  logic [xlen-1:0] a, b, rs2v, res, word, wdata;
  bus_exp_t bx;
  wb_pay_t  w;
  rf_wr_t   pw;
  while (pend_q.size() != 0 && int'(pend_q[0].tag) + 4 <= j) begin
    pw = pend_q.pop_front();
    shadow_rf[pw.rd] = pw.data;
  end
  rs2v = rf_read(i[24:20]);
  case (c.op0_sel)
    op0_rs1: a = rf_read(i[19:15]);
    op0_pc:  a = pc;
    op0_pc4: a = pc + 32'd4;
    default: a = '0;
  endcase
  b = op1_value(c.op1_sel, i, rs2v);
  res = alu_model(c.alu_fn, a, b);
  x_op0[j] = a;
  x_op1[j] = b;
  if (taken_model(c.br_type, cond_of(a, b))) br_target[j] = pc + op1_value(op1_imm_sb, i, '0);
  wdata = res;
  if (c.mem_op != mem_none) begin
    is_mem[j] = 1'b1;
    bx = bus_fields(res, c.mem_len, rs2v, c.mem_op == mem_store);
    exp_bus_q.push_back(bx);
    word = model_mem.exists(bx.adr) ? model_mem[bx.adr] : fill_word(bx.adr);
    if (bx.we) model_mem[bx.adr] = merge_bytes(word, bx.dat, bx.sel);
    if (c.wb_sel == wb_mem) wdata = load_ext(word, res[1:0], c.mem_len);
  end
  w.rd     = i[11:7];
  w.data   = wdata;
  w.rf_wen = c.rf_wen;
  exp_wb_q.push_back(w);
  if (c.rf_wen && i[11:7] != 0) begin
    pw.tag  = j;
    pw.rd   = i[11:7];
    pw.data = wdata;
    pend_q.push_back(pw);
  end
endtask

`endif

// File: tb_riscv_dpath.sv
/* Testbench for the RISC-V datapath. Issues a random program with control
   words, answers Wishbone with random delays and checks against the model */
`timescale 1ns/1ns

module tb_riscv_dpath import riscv_pkg::*; ();

  localparam int n_inst         = 300;
  localparam int n_prologue     = 35;             // 31 register loads, 4 bubbles
  localparam int worst_cpi      = 8;              // Bubble, issue, 4 stall cycles, slack
  localparam int timeout_cycles = (n_inst + n_prologue) * worst_cpi + 5 + 100;

  logic                  clk;
  logic                  reset;
  logic [xlen-1:0]       imem_addr;
  logic [xlen-1:0]       inst;
  logic                  issue_valid;
  ctrl_t                 ctrl;
  logic                  issue_rdy;
  logic                  wb_cyc, wb_stb, wb_we;
  logic [xlen-1:0]       wb_adr, wb_dat_w, wb_dat_r;
  logic [sel_w-1:0]      wb_sel;
  logic                  wb_ack;
  logic                  wb_valid;
  logic [reg_addr_w-1:0] wb_rd;
  logic [xlen-1:0]       wb_data;
  br_cond_t              br_cond;

  logic [31:0]     lfsr_state = 32'hdb2309cb;
  logic [xlen-1:0] model_pc;
  logic            prev_adv = 1'b1;     // Last edge advanced the pipe
  int adv_cnt   = 0;                    // Advancing edges since reset
  int ack_wait  = -1;                   // Idle when negative
  int cyc_cnt   = 0;
  int wb_errs   = 0;
  int bus_errs  = 0;
  int cond_errs = 0;
  int pc_errs   = 0;
  int misc_errs = 0;

  `include "tb_riscv_model.svh"

  riscv_dpath riscv_dpath_i (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc_cnt++;
    if (cyc_cnt > timeout_cycles) begin
      $display("Timeout after %0d cycles, pipeline stopped making progress", cyc_cnt);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int k = 0; k < n; k++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  // --------------------
  // Compare tasks
  // --------------------
  task automatic check_wb(input wb_pay_t got, input wb_pay_t exp);
    if (got.rd !== exp.rd || got.data !== exp.data) begin   // rf_wen not on a port
      wb_errs++;
      $display("** Error wb_rd/wb_data got %h/%h exp %h/%h at %0t",
               got.rd, got.data, exp.rd, exp.data, $time);
    end
  endtask

  task automatic check_bus(input logic [xlen-1:0] adr, input logic [xlen-1:0] dat,
                           input logic [sel_w-1:0] sel, input logic we, input bus_exp_t exp);
    if (adr !== exp.adr || sel !== exp.sel || we !== exp.we || (exp.we && dat !== exp.dat)) begin
      bus_errs++;
      $display("** Error wb_adr/wb_dat_w/wb_sel/wb_we got %h/%h/%h/%h exp %h/%h/%h/%h at %0t",
               adr, dat, sel, we, exp.adr, exp.dat, exp.sel, exp.we, $time);
    end
  endtask

  task automatic check_cond(input br_cond_t got, input br_cond_t exp);
    if (got !== exp) begin
      cond_errs++;
      $display("** Error br_cond got %h exp %h at %0t", got, exp, $time);
    end
  endtask

  task automatic check_pc(input logic [xlen-1:0] got, input logic [xlen-1:0] exp);
    if (got !== exp) begin
      pc_errs++;
      $display("** Error imem_addr got %h exp %h at %0t", got, exp, $time);
    end
  endtask

  // Wishbone slave with 0 to 3 wait cycles
  task automatic respond();
    logic [xlen-1:0] word;
    wb_ack = 1'b0;
    if (wb_cyc && wb_stb) begin
      if (ack_wait < 0) ack_wait = rand_bits(2);
      if (ack_wait == 0) begin
        word = bus_mem.exists(wb_adr) ? bus_mem[wb_adr] : fill_word(wb_adr);
        wb_ack   = 1'b1;
        wb_dat_r = word;
        if (wb_we) bus_mem[wb_adr] = merge_bytes(word, wb_dat_w, wb_sel);
        ack_wait = -1;
      end else begin
        ack_wait--;
      end
    end
  endtask

  // One clock: drive on the falling edge, check mid-cycle
  task automatic run_cycle(input logic v, input ctrl_t c, input logic [xlen-1:0] ins,
                           output logic accepted);
    logic    exp_rdy;
    logic    exp_cyc;
    int      xt;
    wb_pay_t got_wb;
    @(negedge clk);
    issue_valid = v;
    ctrl        = c;
    inst        = ins;
    respond();
    #2;
    check_pc(imem_addr, model_pc);
    xt = adv_cnt - 2;                           // Instruction now in execute
    if (x_op0.exists(xt)) check_cond(br_cond, cond_of(x_op0[xt], x_op1[xt]));
    exp_rdy = !is_mem.exists(adv_cnt - 3) || wb_ack;
    if (issue_rdy !== exp_rdy) begin
      misc_errs++;
      $display("** Error issue_rdy got %h exp %h at %0t", issue_rdy, exp_rdy, $time);
    end
    // Bus cycle opens the cycle after the access enters memory
    exp_cyc = is_mem.exists(adv_cnt - 3) && !prev_adv;
    if (wb_cyc !== exp_cyc || wb_stb !== exp_cyc) begin
      misc_errs++;
      $display("** Error wb_cyc/wb_stb got %h/%h exp %h at %0t",
               wb_cyc, wb_stb, exp_cyc, $time);
    end
    if (wb_cyc) begin
      if (exp_bus_q.size() == 0) begin
        misc_errs++;
        $display("Bus cycle started with no access expected at %0t", $time);
      end else begin
        check_bus(wb_adr, wb_dat_w, wb_sel, wb_we, exp_bus_q[0]);
        if (wb_ack) void'(exp_bus_q.pop_front());
      end
    end
    accepted = issue_rdy;
    prev_adv = issue_rdy;
    if (issue_rdy) begin
      if (wb_valid) begin
        if (exp_wb_q.size() == 0) begin
          misc_errs++;
          $display("Writeback of rd %0d appeared with none expected at %0t", wb_rd, $time);
        end else begin
          got_wb.rd     = wb_rd;
          got_wb.data   = wb_data;
          got_wb.rf_wen = 1'b0;
          check_wb(got_wb, exp_wb_q.pop_front());
        end
      end
      if (v) model_issue(adv_cnt, c, ins, model_pc);
      if (br_target.exists(adv_cnt - 2)) model_pc = br_target[adv_cnt - 2];
      else if (v) model_pc = model_pc + 32'd4;
      adv_cnt++;
    end
  endtask

  task automatic issue(input logic v, input ctrl_t c, input logic [xlen-1:0] ins);
    logic acc;
    acc = 1'b0;
    while (!acc) run_cycle(v, c, ins, acc);
  endtask

  // Random instruction with its control word
  task automatic gen_inst(output ctrl_t c, output logic [xlen-1:0] ins);
    logic [2:0]  kind;
    logic [2:0]  op1;
    logic [5:0]  off;
    mem_len_t    len;
    c    = '0;
    kind = rand_bits(3);
    if (kind <= 3) begin                        // ALU over any operand source
      op1 = rand_bits(3);
      if (op1 == 3'd7) op1 = 3'd0;
      c.op0_sel = op0_sel_t'(rand_bits(2));
      c.op1_sel = op1_sel_t'(op1);
      c.alu_fn  = alu_fn_t'(rand_bits(4) % 11);
      c.rf_wen  = 1'b1;
      ins       = rand_bits(32);
    end else if (kind == 4) begin               // Conditional branch
      c.br_type = br_type_t'(1 + rand_bits(3) % 6);
      ins       = rand_bits(32);
    end else begin                              // Load or store in the window
      len = mem_len_t'(rand_bits(3) % 5);
      off = rand_bits(6);
      if (len == len_w) off = off & 6'h3c;
      else if (len == len_h || len == len_hu) off = off & 6'h3e;
      c.op0_sel = op0_zero;
      c.mem_len = len;
      if (kind == 7) begin
        c.op1_sel = op1_imm_s;
        c.mem_op  = mem_store;
        ins = enc_store(rand_bits(5), 12'h100 + off, rand_bits(5));
      end else begin
        c.op1_sel = op1_imm_i;
        c.mem_op  = mem_load;
        c.wb_sel  = wb_mem;
        c.rf_wen  = 1'b1;
        ins = enc_load(rand_bits(5), 12'h100 + off, rand_bits(5));
      end
    end
  endtask

  initial begin
    ctrl_t           c;
    logic [xlen-1:0] ins;
    logic [19:0]     imm_hi;
    int              total;
    reset       = 1'b1;
    issue_valid = 1'b0;
    ctrl        = '0;
    inst        = '0;
    wb_dat_r    = '0;
    wb_ack      = 1'b0;
    model_pc    = reset_vector;
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    #2;
    check_pc(imem_addr, reset_vector);
    if (wb_valid !== 1'b0 || wb_cyc !== 1'b0) begin
      misc_errs++;
      $display("wb_valid or wb_cyc not low after reset");
    end

    // ----------------------
    // Prologue, every register gets a known value
    // ----------------------
    for (int r = 1; r < 32; r++) begin
      c         = '0;
      c.op0_sel = op0_zero;
      c.op1_sel = op1_imm_u;
      c.rf_wen  = 1'b1;
      imm_hi    = rand_bits(20);
      ins       = {imm_hi, r[4:0], 7'b0110111};
      issue(1'b1, c, ins);
    end
    repeat (4) issue(1'b0, '0, '0);

    for (int n = 0; n < n_inst; n++) begin
      if (rand_bits(2) == 0) issue(1'b0, '0, '0);   // Occasional bubble
      gen_inst(c, ins);
      issue(1'b1, c, ins);
    end

    // Drain, then look for stray writebacks
    while (exp_wb_q.size() != 0 || exp_bus_q.size() != 0) issue(1'b0, '0, '0);
    repeat (5) issue(1'b0, '0, '0);

    total = wb_errs + bus_errs + cond_errs + pc_errs + misc_errs;
    $display("Errors: wb %0d, bus %0d, cond %0d, pc %0d, other %0d",
             wb_errs, bus_errs, cond_errs, pc_errs, misc_errs);
    if (total == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule
